// ==== verilog/cfg_pkg.sv ====
`default_nettype none

package cfg_pkg;

    // Field widths of the configuration port and the register map.
    typedef logic [5:0]  cfg_addr_t;
    typedef logic [11:0] cfg_data_t;
    typedef logic [9:0]  ratio_t;
    typedef logic [1:0]  vcodiv_t;
    typedef logic [2:0]  trng_sel_t;
    typedef logic [3:0]  noise_mask_t;

    localparam int NUM_RATIO       = 3;
    localparam int NUM_TRNG        = 32;
    localparam int NUM_NOISE_GRP   = 4;
    localparam int NUM_NOISE_LINES = 8;
    localparam int TRNG_PER_GRP    = NUM_TRNG / NUM_NOISE_GRP;

    // Selects packed into one write at the packed addresses.
    localparam int SEL_PER_PACK    = 4;

    localparam int FRAME_BITS      = 18;
    localparam int RX_CNT_W        = $clog2(FRAME_BITS);

    // Register addresses.
    localparam cfg_addr_t ADDR_PLLEN        = 6'd0;
    localparam cfg_addr_t ADDR_VCODIV       = 6'd1;
    localparam cfg_addr_t ADDR_RSTBYP       = 6'd2;
    localparam cfg_addr_t ADDR_RATIO0       = 6'd3;
    localparam cfg_addr_t ADDR_TRNG_PACK0   = 6'd6;
    localparam cfg_addr_t ADDR_NOISESEL0    = 6'd14;
    localparam cfg_addr_t ADDR_TRNG_SINGLE0 = 6'd18;

    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rx_state_t;

endpackage

`default_nettype wire

// ==== verilog/cfg_serial_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_serial_rx
    import cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sen,
    input  logic      sdi,
    output logic      valid,
    output cfg_addr_t addr,
    output cfg_data_t data
);

    rx_state_t             state;
    logic [RX_CNT_W-1:0]   bit_cnt;
    logic [FRAME_BITS-1:0] shift_q;
    logic                  frame_done;

    // Frame FSM. The counter holds the number of bits already taken.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (sen) begin
                        bit_cnt <= RX_CNT_W'(1);
                        state   <= RX_SHIFT;
                    end
                end
                RX_SHIFT: begin
                    if (!sen) begin
                        // Aborted frame, drop it.
                        bit_cnt <= '0;
                        state   <= RX_IDLE;
                    end else if (bit_cnt == RX_CNT_W'(FRAME_BITS - 1)) begin
                        bit_cnt    <= '0;
                        frame_done <= 1'b1;
                        state      <= RX_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    bit_cnt <= '0;
                    state   <= RX_IDLE;
                end
            endcase
        end
    end

    // MSB first, so the address ends up in the top bits.
    always_ff @(posedge clk) begin
        if (sen) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], sdi};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= frame_done;
        end
    end

    // Capture before the next frame shifts over the register.
    always_ff @(posedge clk) begin
        if (frame_done) begin
            addr <= shift_q[FRAME_BITS-1 -: $bits(cfg_addr_t)];
            data <= shift_q[$bits(cfg_data_t)-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/memmap_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module memmap_regs
    import cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  cfg_addr_t   addr,
    input  cfg_data_t   data,
    output ratio_t      reg_ratio [NUM_RATIO],
    output logic        reg_pllen,
    output vcodiv_t     reg_vcodiv,
    output trng_sel_t   reg_trngsel [NUM_TRNG],
    output noise_mask_t reg_noisesel [NUM_NOISE_GRP],
    output logic        reg_idfx_fscan_rstbypen
);

    ratio_t      next_ratio [NUM_RATIO];
    logic        next_pllen;
    vcodiv_t     next_vcodiv;
    trng_sel_t   next_trngsel [NUM_TRNG];
    noise_mask_t next_noisesel [NUM_NOISE_GRP];
    logic        next_rstbypen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_pllen               <= 1'b0;
            reg_vcodiv              <= '0;
            reg_idfx_fscan_rstbypen <= 1'b0;
            reg_ratio               <= '{default: '0};
            reg_trngsel             <= '{default: '0};
            reg_noisesel            <= '{default: '0};
        end else begin
            reg_pllen               <= next_pllen;
            reg_vcodiv              <= next_vcodiv;
            reg_idfx_fscan_rstbypen <= next_rstbypen;
            reg_ratio               <= next_ratio;
            reg_trngsel             <= next_trngsel;
            reg_noisesel            <= next_noisesel;
        end
    end

    // Every field holds unless its address is written.
    always_comb begin
        next_pllen    = reg_pllen;
        next_vcodiv   = reg_vcodiv;
        next_rstbypen = reg_idfx_fscan_rstbypen;
        next_ratio    = reg_ratio;
        next_trngsel  = reg_trngsel;
        next_noisesel = reg_noisesel;

        if (valid) begin
            case (addr)
                ADDR_PLLEN:  next_pllen    = data[0];
                ADDR_VCODIV: next_vcodiv   = data[$bits(vcodiv_t)-1:0];
                ADDR_RSTBYP: next_rstbypen = data[0];

                // Single selects, 20 and 25 both land on select 4.
                ADDR_TRNG_SINGLE0: begin
                    next_trngsel[15] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd1: begin
                    next_trngsel[16] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd2: begin
                    next_trngsel[4] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd3: begin
                    next_trngsel[0] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd4: begin
                    next_trngsel[1] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd5: begin
                    next_trngsel[2] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd6: begin
                    next_trngsel[3] = data[$bits(trng_sel_t)-1:0];
                end
                ADDR_TRNG_SINGLE0 + 6'd7: begin
                    next_trngsel[4] = data[$bits(trng_sel_t)-1:0];
                end
                default: begin
                end
            endcase

            for (int k = 0; k < NUM_RATIO; k++) begin
                if (addr == ADDR_RATIO0 + cfg_addr_t'(k)) begin
                    next_ratio[k] = data[$bits(ratio_t)-1:0];
                end
            end

            for (int k = 0; k < NUM_NOISE_GRP; k++) begin
                if (addr == ADDR_NOISESEL0 + cfg_addr_t'(k)) begin
                    next_noisesel[k] = data[$bits(noise_mask_t)-1:0];
                end
            end

            // Lowest select of the group sits in the top data bits.
            for (int k = 0; k < NUM_TRNG / SEL_PER_PACK; k++) begin
                if (addr == ADDR_TRNG_PACK0 + cfg_addr_t'(k)) begin
                    for (int j = 0; j < SEL_PER_PACK; j++) begin
                        next_trngsel[SEL_PER_PACK*k + j] =
                            data[$bits(cfg_data_t)-1 - $bits(trng_sel_t)*j -: $bits(trng_sel_t)];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trng_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module trng_sampler
    import cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [NUM_NOISE_LINES-1:0] noise_in,
    input  trng_sel_t                  reg_trngsel [NUM_TRNG],
    input  noise_mask_t                reg_noisesel [NUM_NOISE_GRP],
    output logic [NUM_TRNG-1:0]        trng_word
);

    logic [NUM_NOISE_GRP-1:0] grp_parity;
    logic [NUM_TRNG-1:0]      next_word;

    // Whitening bit per group from the masked upper noise lines.
    always_comb begin
        for (int g = 0; g < NUM_NOISE_GRP; g++) begin
            grp_parity[g] = ^(noise_in[NUM_NOISE_LINES-1 -: $bits(noise_mask_t)]
                              & reg_noisesel[g]);
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_TRNG; i++) begin
            next_word[i] = noise_in[reg_trngsel[i]] ^ grp_parity[i / TRNG_PER_GRP];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trng_word <= '0;
        end else begin
            trng_word <= next_word;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_top
    import cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sen,
    input  logic                       sdi,
    input  logic [NUM_NOISE_LINES-1:0] noise_in,
    output logic                       reg_pllen,
    output vcodiv_t                    reg_vcodiv,
    output logic                       reg_idfx_fscan_rstbypen,
    output ratio_t                     reg_ratio [NUM_RATIO],
    output logic [NUM_TRNG-1:0]        trng_word
);

    logic        valid;
    cfg_addr_t   addr;
    cfg_data_t   data;
    trng_sel_t   reg_trngsel [NUM_TRNG];
    noise_mask_t reg_noisesel [NUM_NOISE_GRP];

    cfg_serial_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .sen   (sen),
        .sdi   (sdi),
        .valid (valid),
        .addr  (addr),
        .data  (data)
    );

    memmap_regs u_regs (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .valid                   (valid),
        .addr                    (addr),
        .data                    (data),
        .reg_ratio               (reg_ratio),
        .reg_pllen               (reg_pllen),
        .reg_vcodiv              (reg_vcodiv),
        .reg_trngsel             (reg_trngsel),
        .reg_noisesel            (reg_noisesel),
        .reg_idfx_fscan_rstbypen (reg_idfx_fscan_rstbypen)
    );

    trng_sampler u_trng (
        .clk          (clk),
        .rst_n        (rst_n),
        .noise_in     (noise_in),
        .reg_trngsel  (reg_trngsel),
        .reg_noisesel (reg_noisesel),
        .trng_word    (trng_word)
    );

endmodule

`default_nettype wire

// ==== test/cfg_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_checker
    import cfg_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        valid,
    input cfg_addr_t   addr,
    input logic        reg_pllen,
    input logic        reg_idfx_fscan_rstbypen,
    input vcodiv_t     reg_vcodiv,
    input ratio_t      reg_ratio [NUM_RATIO],
    input trng_sel_t   reg_trngsel [NUM_TRNG],
    input noise_mask_t reg_noisesel [NUM_NOISE_GRP]
);

    // Highest address that the map decodes.
    localparam cfg_addr_t ADDR_LAST = ADDR_TRNG_SINGLE0 + 6'd7;

    logic [NUM_RATIO*$bits(ratio_t)-1:0]          ratio_flat;
    logic [NUM_TRNG*$bits(trng_sel_t)-1:0]        sel_flat;
    logic [NUM_NOISE_GRP*$bits(noise_mask_t)-1:0] mask_flat;
    int                                           fail_cnt = 0;

    always_comb begin
        for (int k = 0; k < NUM_RATIO; k++) begin
            ratio_flat[k*$bits(ratio_t) +: $bits(ratio_t)] = reg_ratio[k];
        end
        for (int k = 0; k < NUM_TRNG; k++) begin
            sel_flat[k*$bits(trng_sel_t) +: $bits(trng_sel_t)] = reg_trngsel[k];
        end
        for (int k = 0; k < NUM_NOISE_GRP; k++) begin
            mask_flat[k*$bits(noise_mask_t) +: $bits(noise_mask_t)] = reg_noisesel[k];
        end
    end

    valid_single: assert property (@(posedge clk) disable iff (!rst_n) valid |=> !valid)
        else begin
            fail_cnt++;
            $error("valid stayed high for two cycles");
        end

    reset_zero: assert property (@(posedge clk) !rst_n |=>
        (!reg_pllen && !reg_idfx_fscan_rstbypen && reg_vcodiv == '0
         && ratio_flat == '0 && sel_flat == '0 && mask_flat == '0))
        else begin
            fail_cnt++;
            $error("register output not zero after reset");
        end

    // Idle cycles and unmapped writes keep the clock fields.
    hold_fields: assert property (@(posedge clk) disable iff (!rst_n)
        (!valid || addr > ADDR_LAST) |=>
        ($stable(reg_pllen) && $stable(reg_vcodiv) && $stable(ratio_flat)))
        else begin
            fail_cnt++;
            $error("clock field changed without a mapped write");
        end

endmodule

bind memmap_regs cfg_checker u_chk (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .valid                   (valid),
    .addr                    (addr),
    .reg_pllen               (reg_pllen),
    .reg_idfx_fscan_rstbypen (reg_idfx_fscan_rstbypen),
    .reg_vcodiv              (reg_vcodiv),
    .reg_ratio               (reg_ratio),
    .reg_trngsel             (reg_trngsel),
    .reg_noisesel            (reg_noisesel)
);

`default_nettype wire

// ==== test/tb_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cfg_top
    import cfg_pkg::*;
();

    localparam int RST_CYCLES  = 3;
    localparam int FULL_FRAMES = 24 + 2 * 12 + 2 * 8 + 16 + 8;
    localparam int CYCLE_LIMIT = RST_CYCLES + FULL_FRAMES * (FRAME_BITS + 1)
                                 + 8 * FRAME_BITS + 6 * 8 + 200;
    localparam int SINGLE_MAP [8] = '{15, 16, 4, 0, 1, 2, 3, 4};

    logic                       clk;
    logic                       rst_n;
    logic                       sen;
    logic                       sdi;
    logic [NUM_NOISE_LINES-1:0] noise_in;
    logic                       reg_pllen;
    logic                       reg_idfx_fscan_rstbypen;
    vcodiv_t                    reg_vcodiv;
    ratio_t                     reg_ratio [NUM_RATIO];
    logic [NUM_TRNG-1:0]        trng_word;

    // Reference model of the register map.
    logic        m_pllen;
    logic        m_rstbyp;
    vcodiv_t     m_vcodiv;
    ratio_t      m_ratio [NUM_RATIO];
    trng_sel_t   m_sel [NUM_TRNG];
    noise_mask_t m_mask [NUM_NOISE_GRP];
    logic [NUM_TRNG-1:0] exp_word;

    // Pending writes. Each one is applied at the cycle in due_q.
    int        due_q [$];
    cfg_addr_t addr_q [$];
    cfg_data_t data_q [$];

    logic [31:0] stim_state;
    logic [31:0] noise_state;
    logic        noise_on;
    int          cycle;
    int          err_cnt;
    int          check_cnt;
    int          tests_run;
    int          tests_failed;

    cfg_top dut (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .sen                     (sen),
        .sdi                     (sdi),
        .noise_in                (noise_in),
        .reg_pllen               (reg_pllen),
        .reg_vcodiv              (reg_vcodiv),
        .reg_idfx_fscan_rstbypen (reg_idfx_fscan_rstbypen),
        .reg_ratio               (reg_ratio),
        .trng_word               (trng_word)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    function automatic int total_errors();
        return err_cnt + dut.u_regs.u_chk.fail_cnt;
    endfunction

    // Each bit is its selected line XOR the masked parity of lines 7..4.
    function automatic logic [NUM_TRNG-1:0] expected_word(input logic [7:0] n);
        logic [NUM_TRNG-1:0] w;
        logic                par;
        for (int i = 0; i < NUM_TRNG; i++) begin
            par  = ^(n[7:4] & m_mask[i / 8]);
            w[i] = n[m_sel[i]] ^ par;
        end
        return w;
    endfunction

    task automatic apply_write(input cfg_addr_t a, input cfg_data_t d);
        int k;
        k = int'(a);
        if (k == 0) m_pllen = d[0];
        else if (k == 1) m_vcodiv = d[1:0];
        else if (k == 2) m_rstbyp = d[0];
        else if (k >= 3 && k <= 5) m_ratio[k-3] = d[9:0];
        else if (k >= 6 && k <= 13) begin
            for (int j = 0; j < 4; j++) begin
                m_sel[4*(k-6) + j] = d[11 - 3*j -: 3];
            end
        end
        else if (k >= 14 && k <= 17) m_mask[k-14] = d[3:0];
        else if (k >= 18 && k <= 25) m_sel[SINGLE_MAP[k-18]] = d[2:0];
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    // Drives reset and noise, applies due writes and compares every cycle.
    always @(negedge clk) begin
        if (cycle == RST_CYCLES) rst_n = 1'b1;
        if (cycle >= RST_CYCLES) begin
            while (due_q.size() > 0 && due_q[0] == cycle) begin
                apply_write(addr_q.pop_front(), data_q.pop_front());
                void'(due_q.pop_front());
            end
            check_val("reg_pllen", reg_pllen, m_pllen);
            check_val("reg_vcodiv", reg_vcodiv, m_vcodiv);
            check_val("reg_idfx_fscan_rstbypen", reg_idfx_fscan_rstbypen, m_rstbyp);
            for (int k = 0; k < NUM_RATIO; k++) begin
                check_val($sformatf("reg_ratio[%0d]", k), reg_ratio[k], m_ratio[k]);
            end
            check_val("trng_word", trng_word, exp_word);
            noise_state = xorshift32(noise_state);
            noise_in = noise_on ? noise_state[7:0] : '0;
            exp_word = expected_word(noise_in);
        end
    end

    task automatic send_frame(input cfg_addr_t a, input cfg_data_t d);
        logic [FRAME_BITS-1:0] f;
        f = {a, d};
        for (int b = FRAME_BITS - 1; b >= 0; b--) begin
            @(negedge clk);
            sen = 1'b1;
            sdi = f[b];
        end
        // The last bit lands at the next edge and the register two edges later.
        due_q.push_back(cycle + 3);
        addr_q.push_back(a);
        data_q.push_back(d);
    endtask

    task automatic send_partial(input int len);
        logic [31:0] r;
        for (int b = 0; b < len; b++) begin
            r = next_rand();
            @(negedge clk);
            sen = 1'b1;
            sdi = r[0];
        end
        @(negedge clk);
        sen = 1'b0;
        sdi = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            sen = 1'b0;
            sdi = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        int errs;
        idle(6);
        errs = total_errors() - err_before;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %-22s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAIL", errs);
    endtask

    initial begin
        int e;
        logic [31:0] r;
        rst_n = 1'b0;
        sen = 1'b0;
        sdi = 1'b0;
        // Noise lines stay high through reset.
        noise_in = '1;
        noise_on = 1'b0;
        exp_word = '0;
        stim_state = 32'd26472;
        noise_state = 32'd26472 ^ 32'h9e37_79b9;
        {m_pllen, m_rstbyp, m_vcodiv} = '0;
        m_ratio = '{default: '0};
        m_sel = '{default: '0};
        m_mask = '{default: '0};
        wait (rst_n === 1'b1);

        // Still the state left by the last reset edge.
        e = total_errors();
        check_val("reg_pllen", reg_pllen, '0);
        check_val("reg_vcodiv", reg_vcodiv, '0);
        check_val("reg_idfx_fscan_rstbypen", reg_idfx_fscan_rstbypen, '0);
        for (int k = 0; k < NUM_RATIO; k++) begin
            check_val($sformatf("reg_ratio[%0d]", k), reg_ratio[k], '0);
        end
        check_val("trng_word", trng_word, '0);
        report_test("reset_values", e);

        e = total_errors();
        for (int i = 0; i < 24; i++) begin
            r = next_rand();
            send_frame(cfg_addr_t'(r % 6), cfg_data_t'(r >> 8));
            if (r[31]) idle(1);
        end
        report_test("clock_fields", e);

        e = total_errors();
        noise_on = 1'b1;
        for (int round = 0; round < 2; round++) begin
            for (int a = 6; a <= 17; a++) begin
                send_frame(cfg_addr_t'(a), cfg_data_t'(next_rand()));
            end
        end
        report_test("packed_selects_masks", e);

        // Addresses 20 and 25 both hit select 4 and the later one wins.
        e = total_errors();
        for (int round = 0; round < 2; round++) begin
            for (int a = 18; a <= 25; a++) begin
                send_frame(cfg_addr_t'(a), cfg_data_t'(next_rand()));
            end
        end
        report_test("single_selects", e);

        e = total_errors();
        for (int i = 0; i < 16; i++) begin
            send_frame(cfg_addr_t'(26 + next_rand() % 38), cfg_data_t'(next_rand()));
        end
        report_test("unmapped_addresses", e);

        e = total_errors();
        for (int i = 0; i < 8; i++) begin
            send_partial(1 + int'(next_rand() % 17));
            send_frame(cfg_addr_t'(next_rand() % 26), cfg_data_t'(next_rand()));
        end
        report_test("aborted_frames", e);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_cnt, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/cfg_pkg.sv
verilog/cfg_serial_rx.sv
verilog/memmap_regs.sv
verilog/trng_sampler.sv
verilog/cfg_top.sv
test/cfg_checker.sv
test/tb_cfg_top.sv
